// File: sources.f
src/ext_harness_pkg.sv
src/switch_ack_model.sv
src/obi_req_fifo.sv
src/slow_memory.sv
src/gpio_cnt.sv
src/ext_harness.sv
testbench/tb_ext_harness.sv

// File: Makefile
# Verilator build and run for the external device harness

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f sources.f \
		--top-module tb_ext_harness -Mdir obj_dir -o sim_ext_harness
	./obj_dir/sim_ext_harness | tee sim.log
	@if grep -qF "*** TEST PASSED ***" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_ext_harness.sv
/*
 * testbench for the external device harness
 * lfsr stimulus, models for ack delay, memory path and gpio counter, watchdog
 */
`timescale 1ns/10ps

module tb_ext_harness import ext_harness_pkg::*; ();

  localparam int unsigned CLK_HALF     = 20;
  localparam int unsigned CLK_PERIOD   = 2 * CLK_HALF;
  localparam int unsigned DRIVE_DLY    = 2;
  localparam int unsigned RESET_CYCLES = 8;
  localparam logic [15:0] LFSR_SEED    = 16'd11946;
  localparam int unsigned ACK_CYCLES   = 200;
  localparam int unsigned WINDOW_WORDS = 16;
  localparam int unsigned TRAFFIC_REQS = 300;
  localparam int unsigned LAT_REQS     = 4;
  localparam int unsigned GPIO_PAIRS   = 200;
  // fifo full plus one request in the memory, all still to answer
  localparam int unsigned DRAIN_CYCLES = (FIFO_DEPTH + 1) * (MEM_LATENCY + 1) + 4;
  // worst case per request, fifo full ahead of it
  localparam int unsigned REQ_CYCLES   = 3 * (MEM_LATENCY + 2);
  localparam int unsigned TOTAL_CYCLES = RESET_CYCLES + ACK_CYCLES + SWITCH_ACK_LATENCY
                                       + (3 + WINDOW_WORDS + TRAFFIC_REQS + LAT_REQS) * REQ_CYCLES
                                       + GPIO_PAIRS * 8;
  localparam int unsigned TIMEOUT_NS   = (TOTAL_CYCLES + 1000) * CLK_PERIOD;

  logic                         clk_i;
  logic                         reset_i;
  logic [NUM_POWER_DOMAINS-1:0] switch_n_i;
  logic [NUM_POWER_DOMAINS-1:0] switch_ack_n_o;
  logic                         mem_req_i;
  logic                         mem_we_i;
  logic [BUS_BE_W-1:0]          mem_be_i;
  logic [BUS_ADDR_W-1:0]        mem_addr_i;
  logic [BUS_DATA_W-1:0]        mem_wdata_i;
  logic                         mem_gnt_o;
  logic                         mem_rvalid_o;
  logic [BUS_DATA_W-1:0]        mem_rdata_o;
  logic                         gpio_i;
  logic                         gpio_o;

  // model state
  logic [15:0]                  lfsr_q;
  logic [NUM_POWER_DOMAINS-1:0] ack_hist [$];
  logic [BUS_DATA_W-1:0]        shadow_mem [MEM_WORDS];
  logic                         exp_is_read [$];
  logic [BUS_DATA_W-1:0]        exp_rdata [$];
  logic [BUS_DATA_W-1:0]        last_rdata;
  int                           grant_count;
  int                           rvalid_count;
  int                           gpio_edges;
  int                           gpio_pulses;
  logic                         gpio_prev;
  logic [1:0]                   pulse_pipe;

  ext_harness u_dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .switch_n_i     (switch_n_i),
    .switch_ack_n_o (switch_ack_n_o),
    .mem_req_i      (mem_req_i),
    .mem_we_i       (mem_we_i),
    .mem_be_i       (mem_be_i),
    .mem_addr_i     (mem_addr_i),
    .mem_wdata_i    (mem_wdata_i),
    .mem_gnt_o      (mem_gnt_o),
    .mem_rvalid_o   (mem_rvalid_o),
    .mem_rdata_o    (mem_rdata_o),
    .gpio_i         (gpio_i),
    .gpio_o         (gpio_o)
  );

  always #CLK_HALF clk_i = ~clk_i;

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %h, actual %h", test_name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic fail_run(input string reason);
    $display("Error: %s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  // 16-bit galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 16'hB400;
    end
    return next;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned width);
    logic [31:0] value;
    value = '0;
    for (int unsigned i = 0; i < width; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = {value[30:0], lfsr_q[0]};
    end
    return value;
  endfunction

  // random word in the window, high bits vary so the memory aliases
  function automatic logic [31:0] rand_addr();
    logic [31:0] addr;
    addr = rand_bits(4) << 12;
    addr = addr | (rand_bits(4) << 2);
    return addr;
  endfunction

  // holds the request until granted, returns at drive time after the grant
  task automatic bus_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata);
    mem_req_i   = 1'b1;
    mem_we_i    = we;
    mem_be_i    = be;
    mem_addr_i  = addr;
    mem_wdata_i = wdata;
    @(posedge clk_i);
    while (!mem_gnt_o) begin
      @(posedge clk_i);
    end
    #DRIVE_DLY;
    mem_req_i = 1'b0;
  endtask

  // outstanding responses, bounded by the worst-case drain time
  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (exp_is_read.size() != 0 && waited < DRAIN_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  // ack delay line model
  always @(posedge clk_i) begin
    if (reset_i) begin
      ack_hist.delete();
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        ack_hist.push_back('1);
      end
    end else begin
      check_value("ack_delay", 32'(ack_hist.pop_front()), 32'(switch_ack_n_o));
      ack_hist.push_back(switch_n_i);
    end
  end

  // shadow memory, expected responses queued in grant order
  always @(posedge clk_i) begin
    logic [MEM_INDEX_W-1:0] idx;
    logic                   is_read;
    logic [BUS_DATA_W-1:0]  expected;
    if (reset_i) begin
      grant_count  = 0;
      rvalid_count = 0;
    end else begin
      if (mem_req_i && mem_gnt_o) begin
        idx = mem_addr_i[MEM_INDEX_W+1:2];
        grant_count++;
        if (mem_we_i) begin
          for (int b = 0; b < BUS_BE_W; b++) begin
            if (mem_be_i[b]) begin
              shadow_mem[idx][b*8 +: 8] = mem_wdata_i[b*8 +: 8];
            end
          end
          exp_is_read.push_back(1'b0);
          exp_rdata.push_back('0);
        end else begin
          exp_is_read.push_back(1'b1);
          exp_rdata.push_back(shadow_mem[idx]);
        end
      end
      if (mem_rvalid_o) begin
        if (exp_is_read.size() == 0) begin
          fail_run("rvalid seen with no outstanding request");
        end else begin
          is_read  = exp_is_read.pop_front();
          expected = exp_rdata.pop_front();
          rvalid_count++;
          if (is_read) begin
            check_value("mem_read", expected, mem_rdata_o);
            last_rdata = mem_rdata_o;
          end
        end
      end
    end
  end

  // edge counter model, pulse expected two samples after the edge
  always @(posedge clk_i) begin
    if (reset_i) begin
      gpio_prev   = 1'b0;
      pulse_pipe  = '0;
      gpio_edges  = 0;
      gpio_pulses = 0;
    end else begin
      check_value("gpio_pulse", 32'(pulse_pipe[1]), 32'(gpio_o));
      if (gpio_o) begin
        gpio_pulses++;
      end
      pulse_pipe[1] = pulse_pipe[0];
      pulse_pipe[0] = 1'b0;
      if (gpio_i && !gpio_prev) begin
        gpio_edges++;
        pulse_pipe[0] = ((gpio_edges % GPIO_CNT_MAX) == 0);
      end
      gpio_prev = gpio_i;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    fail_run("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    int unsigned hold;
    int          cycles;
    logic [31:0] addr;
    logic [31:0] first_word;
    logic [31:0] second_word;
    logic [31:0] merged;
    logic [3:0]  be;
    logic        we_bit;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    lfsr_q      = LFSR_SEED;
    last_rdata  = '0;
    switch_n_i  = '1;
    mem_req_i   = 1'b0;
    mem_we_i    = 1'b0;
    mem_be_i    = '0;
    mem_addr_i  = '0;
    mem_wdata_i = '0;
    gpio_i      = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    reset_i = 1'b0;

    // reset state with idle inputs
    @(posedge clk_i);
    check_value("reset_ack", 32'({NUM_POWER_DOMAINS{1'b1}}), 32'(switch_ack_n_o));
    check_value("reset_gnt", 32'(0), 32'(mem_gnt_o));
    check_value("reset_rvalid", 32'(0), 32'(mem_rvalid_o));
    check_value("reset_gpio", 32'(0), 32'(gpio_o));
    #DRIVE_DLY;

    // random switch patterns, the ack monitor checks every cycle
    repeat (ACK_CYCLES) begin
      switch_n_i = NUM_POWER_DOMAINS'(rand_bits(NUM_POWER_DOMAINS));
      @(posedge clk_i);
      #DRIVE_DLY;
    end

    // full write, partial write, read back
    addr        = rand_addr();
    first_word  = rand_bits(32);
    bus_access(1'b1, 4'hf, addr, first_word);
    second_word = rand_bits(32);
    be          = 4'(rand_bits(4));
    bus_access(1'b1, be, addr, second_word);
    bus_access(1'b0, 4'h0, addr, 32'h0);
    wait_drain();
    merged = first_word;
    for (int b = 0; b < BUS_BE_W; b++) begin
      if (be[b]) begin
        merged[b*8 +: 8] = second_word[b*8 +: 8];
      end
    end
    check_value("single_access", merged, last_rdata);

    // known contents for the whole window
    for (int i = 0; i < WINDOW_WORDS; i++) begin
      bus_access(1'b1, 4'hf, 32'(i) << 2, rand_bits(32));
    end

    // back to back traffic, the fifo fills and holds requests off
    repeat (TRAFFIC_REQS) begin
      addr   = rand_addr();
      we_bit = 1'(rand_bits(1));
      be     = 4'(rand_bits(4));
      bus_access(we_bit, be, addr, rand_bits(32));
      if (rand_bits(2) == 0) begin
        @(posedge clk_i);
        #DRIVE_DLY;
      end
    end
    wait_drain();
    check_value("grant_rvalid_count", 32'(grant_count), 32'(rvalid_count));

    // one request at a time into an empty pipeline
    repeat (LAT_REQS) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      bus_access(1'b0, 4'h0, rand_addr(), 32'h0);
      cycles = 0;
      do begin
        @(posedge clk_i);
        cycles++;
      end while (!mem_rvalid_o);
      check_value("uncontended_latency", 32'(MEM_LATENCY + 1), 32'(cycles));
      wait_drain();
    end

    // random length high and low phases on the gpio pin
    repeat (GPIO_PAIRS) begin
      gpio_i = 1'b1;
      hold   = rand_bits(2) + 1;
      repeat (hold) @(posedge clk_i);
      #DRIVE_DLY;
      gpio_i = 1'b0;
      hold   = rand_bits(2) + 1;
      repeat (hold) @(posedge clk_i);
      #DRIVE_DLY;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_value("gpio_pulse_count", 32'(gpio_edges / GPIO_CNT_MAX), 32'(gpio_pulses));

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: src/ext_harness.sv
/*
 * external device harness top level
 * switch ack model, fifo plus slow memory path, gpio counter
 */
`timescale 1ns/10ps

module ext_harness import ext_harness_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_i,
  // power switches
  input  logic [NUM_POWER_DOMAINS-1:0] switch_n_i,
  output logic [NUM_POWER_DOMAINS-1:0] switch_ack_n_o,
  // memory port
  input  logic                         mem_req_i,
  input  logic                         mem_we_i,
  input  logic [BUS_BE_W-1:0]          mem_be_i,
  input  logic [BUS_ADDR_W-1:0]        mem_addr_i,
  input  logic [BUS_DATA_W-1:0]        mem_wdata_i,
  output logic                         mem_gnt_o,
  output logic                         mem_rvalid_o,
  output logic [BUS_DATA_W-1:0]        mem_rdata_o,
  // gpio
  input  logic                         gpio_i,
  output logic                         gpio_o
);

  // fifo to memory
  logic                  fifo_req;
  logic                  fifo_we;
  logic [BUS_BE_W-1:0]   fifo_be;
  logic [BUS_ADDR_W-1:0] fifo_addr;
  logic [BUS_DATA_W-1:0] fifo_wdata;
  logic                  sram_gnt;
  logic                  sram_rvalid;
  logic [BUS_DATA_W-1:0] sram_rdata;

  switch_ack_model u_switch_ack (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .switch_n_i     (switch_n_i),
    .switch_ack_n_o (switch_ack_n_o)
  );

  // extra queueing stage, makes the slow memory slower still
  obi_req_fifo u_req_fifo (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (mem_req_i),
    .we_i     (mem_we_i),
    .be_i     (mem_be_i),
    .addr_i   (mem_addr_i),
    .wdata_i  (mem_wdata_i),
    .gnt_o    (mem_gnt_o),
    .rvalid_o (mem_rvalid_o),
    .rdata_o  (mem_rdata_o),
    .req_o    (fifo_req),
    .we_o     (fifo_we),
    .be_o     (fifo_be),
    .addr_o   (fifo_addr),
    .wdata_o  (fifo_wdata),
    .gnt_i    (sram_gnt),
    .rvalid_i (sram_rvalid),
    .rdata_i  (sram_rdata)
  );

  slow_memory u_slow_memory (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (fifo_req),
    .we_i     (fifo_we),
    .be_i     (fifo_be),
    .addr_i   (fifo_addr),
    .wdata_i  (fifo_wdata),
    .gnt_o    (sram_gnt),
    .rvalid_o (sram_rvalid),
    .rdata_o  (sram_rdata)
  );

  gpio_cnt u_gpio_cnt (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o)
  );

endmodule

// File: src/gpio_cnt.sv
/*
 * gpio rising edge counter
 * pulses the output once every GPIO_CNT_MAX edges
 */
`timescale 1ns/10ps

module gpio_cnt import ext_harness_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic gpio_i,
  output logic gpio_o
);

  logic                  meta_q;
  logic                  sync_q;
  logic                  sync_prev_q;
  logic                  rise;
  logic                  cnt_last;
  logic [GPIO_CNT_W-1:0] cnt_q;

  // two-flop synchronizer, third flop for edge detection
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      meta_q      <= 1'b0;
      sync_q      <= 1'b0;
      sync_prev_q <= 1'b0;
    end else begin
      meta_q      <= gpio_i;
      sync_q      <= meta_q;
      sync_prev_q <= sync_q;
    end
  end

  assign rise     = sync_q & ~sync_prev_q;
  assign cnt_last = (cnt_q == GPIO_CNT_W'(GPIO_CNT_MAX - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (rise) begin
      cnt_q <= cnt_last ? '0 : cnt_q + 1'b1;
    end
  end

  // one cycle wide, only on the wrapping edge
  assign gpio_o = rise & cnt_last;

endmodule

// File: src/slow_memory.sv
/*
 * slow word memory with byte enables
 * one request at a time, fixed latency from grant to rvalid
 */
`timescale 1ns/10ps

module slow_memory import ext_harness_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [BUS_BE_W-1:0]   be_i,
  input  logic [BUS_ADDR_W-1:0] addr_i,
  input  logic [BUS_DATA_W-1:0] wdata_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output logic [BUS_DATA_W-1:0] rdata_o
);

  logic [BUS_DATA_W-1:0]  mem_q [MEM_WORDS];
  logic [BUS_DATA_W-1:0]  rdata_q;
  mem_state_e             state_q;
  logic [MEM_LAT_W-1:0]   lat_cnt_q;
  logic [MEM_INDEX_W-1:0] index;
  logic                   last_cycle;

  // word index, upper address bits alias
  assign index = addr_i[MEM_INDEX_W+1:2];

  assign last_cycle = (lat_cnt_q == MEM_LAT_W'(MEM_LATENCY - 1));
  assign gnt_o      = req_i & (state_q == MEM_IDLE);
  assign rvalid_o   = (state_q == MEM_BUSY) & last_cycle;
  assign rdata_o    = rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= MEM_IDLE;
      lat_cnt_q <= '0;
    end else begin
      case (state_q)
        MEM_IDLE: begin
          if (gnt_o) begin
            state_q   <= MEM_BUSY;
            lat_cnt_q <= '0;
          end
        end
        MEM_BUSY: begin
          // response goes out on the last busy cycle
          if (last_cycle) begin
            state_q   <= MEM_IDLE;
            lat_cnt_q <= '0;
          end else begin
            lat_cnt_q <= lat_cnt_q + 1'b1;
          end
        end
        default: state_q <= MEM_IDLE;
      endcase
    end
  end

  // access happens at grant, read data waits in rdata_q
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        for (int b = 0; b < BUS_BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[index][b*BYTE_W +: BYTE_W] <= wdata_i[b*BYTE_W +: BYTE_W];
          end
        end
      end else begin
        rdata_q <= mem_q[index];
      end
    end
  end

  a_rvalid_busy: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rvalid_o |-> (state_q == MEM_BUSY) && $past(gnt_o, MEM_LATENCY)
  ) else $error("rvalid outside busy state or at wrong latency");

  a_no_gnt_busy: assert property (
    @(posedge clk_i) disable iff (reset_i)
    gnt_o |=> (!gnt_o) [*MEM_LATENCY]
  ) else $error("memory granted while busy");

endmodule

// File: src/obi_req_fifo.sv
/*
 * request fifo between the external bus and the slow memory
 * responses pass straight through
 */
`timescale 1ns/10ps

module obi_req_fifo import ext_harness_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // upstream port, from the external master
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [BUS_BE_W-1:0]   be_i,
  input  logic [BUS_ADDR_W-1:0] addr_i,
  input  logic [BUS_DATA_W-1:0] wdata_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output logic [BUS_DATA_W-1:0] rdata_o,
  // downstream port, towards the memory
  output logic                  req_o,
  output logic                  we_o,
  output logic [BUS_BE_W-1:0]   be_o,
  output logic [BUS_ADDR_W-1:0] addr_o,
  output logic [BUS_DATA_W-1:0] wdata_o,
  input  logic                  gnt_i,
  input  logic                  rvalid_i,
  input  logic [BUS_DATA_W-1:0] rdata_i
);

  // stored requests
  logic                  we_q    [FIFO_DEPTH];
  logic [BUS_BE_W-1:0]   be_q    [FIFO_DEPTH];
  logic [BUS_ADDR_W-1:0] addr_q  [FIFO_DEPTH];
  logic [BUS_DATA_W-1:0] wdata_q [FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  full;
  logic                  empty;
  logic                  push;
  logic                  pop;

  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty = (count_q == '0);

  // accept whenever there is room, even if the head leaves this cycle
  assign gnt_o = req_i & ~full;
  assign push  = gnt_o;
  assign pop   = req_o & gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      we_q[wr_ptr_q]    <= we_i;
      be_q[wr_ptr_q]    <= be_i;
      addr_q[wr_ptr_q]  <= addr_i;
      wdata_q[wr_ptr_q] <= wdata_i;
    end
  end

  // oldest entry offered until the memory grants it
  assign req_o   = ~empty;
  assign we_o    = we_q[rd_ptr_q];
  assign be_o    = be_q[rd_ptr_q];
  assign addr_o  = addr_q[rd_ptr_q];
  assign wdata_o = wdata_q[rd_ptr_q];

  // responses come back in grant order, nothing to reorder
  assign rvalid_o = rvalid_i;
  assign rdata_o  = rdata_i;

  // occupancy never runs past the storage
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (reset_i) count_q <= FIFO_CNT_W'(FIFO_DEPTH)
  ) else $error("request fifo holds more entries than its depth");

  // a waiting downstream request keeps its fields until granted
  a_req_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    req_o && !gnt_i |=> req_o && $stable(we_o) && $stable(be_o) && $stable(addr_o)
      && $stable(wdata_o)
  ) else $error("downstream request changed before its grant");

endmodule

// File: src/switch_ack_model.sv
/*
 * power switch acknowledge model
 * fixed-latency delay line, one bit per power domain
 */
`timescale 1ns/10ps

module switch_ack_model import ext_harness_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [NUM_POWER_DOMAINS-1:0] switch_n_i,
  output logic [NUM_POWER_DOMAINS-1:0] switch_ack_n_o
);

  // stage 0 takes the request, last stage drives the ack
  logic [NUM_POWER_DOMAINS-1:0] ack_pipe_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // all domains report switched off until the pipe refills
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= '1;
      end
    end else begin
      ack_pipe_q[0] <= switch_n_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= ack_pipe_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = ack_pipe_q[SWITCH_ACK_LATENCY-1];

  // once the pipe has run a full latency out of reset, ack mirrors the old request
  a_ack_delay: assert property (
    @(posedge clk_i)
    (!reset_i) [*SWITCH_ACK_LATENCY] |=>
      (switch_ack_n_o == $past(switch_n_i, SWITCH_ACK_LATENCY))
  ) else $error("switch ack does not match request delayed by %0d cycles",
                SWITCH_ACK_LATENCY);

endmodule

// File: src/ext_harness_pkg.sv
/*
 * shared constants for the external device harness
 * bus widths, memory geometry, latencies and the slow memory state type
 */
package ext_harness_pkg;

  // external bus, request/grant/rvalid protocol
  localparam int unsigned BUS_ADDR_W = 32;
  localparam int unsigned BUS_DATA_W = 32;
  localparam int unsigned BUS_BE_W   = 4;
  localparam int unsigned BYTE_W     = BUS_DATA_W / BUS_BE_W;

  // slow memory geometry, index is taken from addr[11:2]
  localparam int unsigned MEM_WORDS   = 1024;
  localparam int unsigned MEM_INDEX_W = $clog2(MEM_WORDS);

  // cycles from memory grant to rvalid
  localparam int unsigned MEM_LATENCY = 4;
  localparam int unsigned MEM_LAT_W   = $clog2(MEM_LATENCY);

  // request fifo in front of the memory
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // power switch acknowledge model
  // bit 0 cpu, bit 1 peripherals, bits 2-3 memory banks, bit 4 external subsystem
  localparam int unsigned SWITCH_ACK_LATENCY = 15;
  localparam int unsigned NUM_POWER_DOMAINS  = 5;

  // gpio rising edges per output pulse
  localparam int unsigned GPIO_CNT_MAX = 32;
  localparam int unsigned GPIO_CNT_W   = $clog2(GPIO_CNT_MAX);

  // slow memory controller state
  typedef enum logic {
    MEM_IDLE,
    MEM_BUSY
  } mem_state_e;

endpackage
